// File: sim.f
+incdir+src
src/sdram_pkg.sv
src/sdram_refresh_timer.sv
src/sdram_ctrl.sv
src/sdram_top.sv
verif/sdram_model.sv
verif/tb_sdram.sv

// File: src/sdram_config.svh
`ifndef SDRAM_CONFIG_SVH
`define SDRAM_CONFIG_SVH

// nop cycles before precharge-all, 20000 on silicon
`define SDRAM_INIT_WAIT 100

// clk_sys cycles between refreshes
`define SDRAM_REFRESH_INTERVAL 300

`define SDRAM_INIT_REFRESHES 8

// cycles per refresh command, tRC
`define SDRAM_REFRESH_GAP 8

// cas latency 2, burst length 1, single write
`define SDRAM_MODE_WORD 13'b0_0010_0010_0000

`define SDRAM_CAS_LATENCY 2

`define SDRAM_BANK_W 2
`define SDRAM_ROW_W 13
`define SDRAM_COL_W 9

// init wait and refresh interval counters
`define SDRAM_TIMER_W 16

`endif

// File: src/sdram_ctrl.sv
`include "sdram_config.svh"

module sdram_ctrl
	import sdram_pkg::*;
(
	input  logic        clk_sys,
	input  logic        rst_i,
	input  logic        cyc_i,
	input  logic        stb_i,
	input  logic        we_i,
	input  logic [3:0]  sel_i,
	input  logic [31:0] adr_i,
	input  logic [31:0] dat_i,
	output logic        ack_o,
	output logic [31:0] dat_o,
	input  logic        refresh_pending_i,
	output logic        refresh_taken_o,
	output logic        init_done_o,
	output sdram_cmd_e  cmd_o,
	output logic [12:0] addr_o,
	output logic [1:0]  ba_o,
	output logic [3:0]  dqm_o,
	output logic        dq_oe_o,
	output logic [31:0] dq_out_o,
	input  logic [31:0] dq_in_i
);

	localparam logic [2:0] ST_INIT      = 3'd0;
	localparam logic [2:0] ST_IDLE      = 3'd1;
	localparam logic [2:0] ST_REFRESH   = 3'd2;
	localparam logic [2:0] ST_READ      = 3'd3;
	localparam logic [2:0] ST_WRITE     = 3'd4;
	localparam logic [2:0] ST_PRECHARGE = 3'd5;

	localparam int TW = `SDRAM_TIMER_W;
	localparam logic [TW-1:0] WAIT_LAST = TW'(`SDRAM_INIT_WAIT - 1);
	localparam logic [TW-1:0] GAP_LAST = TW'(`SDRAM_REFRESH_GAP - 1);
	localparam logic [3:0] INIT_REF_LAST = 4'(`SDRAM_INIT_REFRESHES - 1);
	// READ goes out at step 2
	localparam logic [2:0] READ_CAP_STEP = 3'(2 + `SDRAM_CAS_LATENCY + 1);
	localparam logic [2:0] WRITE_LAST = 3'd4;

	logic [2:0] state;
	logic [2:0] step;
	logic [TW-1:0] cnt;
	logic [3:0] ref_cnt;

	logic bus_cs;
	sdram_addr_u bus_addr;
	logic [12:0] col_addr;

	assign bus_cs = cyc_i & stb_i;
	assign bus_addr.word = adr_i;
	assign col_addr = 13'(bus_addr.f.col); // a10 low, no auto precharge

	always_ff @(posedge clk_sys) begin
		if (rst_i) begin
			state <= ST_INIT;
			step <= '0;
			cnt <= '0;
			ref_cnt <= '0;
			ack_o <= 1'b0;
		end else begin
			if (!bus_cs)
				ack_o <= 1'b0; // master ended the cycle

			case (state)
				ST_INIT: begin
					case (step)
						3'd0: begin
							cnt <= cnt + 1'b1;
							if (cnt == WAIT_LAST) begin
								cnt <= '0;
								step <= 3'd1;
							end
						end
						3'd1: step <= 3'd2;
						3'd2: step <= 3'd3;
						3'd3: begin
							cnt <= cnt + 1'b1;
							if (cnt == GAP_LAST) begin
								cnt <= '0;
								ref_cnt <= ref_cnt + 1'b1;
								if (ref_cnt == INIT_REF_LAST) begin
									ref_cnt <= '0;
									step <= 3'd4;
								end
							end
						end
						3'd4: step <= 3'd5;
						default: begin
							state <= ST_IDLE;
							step <= '0;
						end
					endcase
				end

				ST_IDLE: begin
					if (refresh_pending_i) begin
						state <= ST_REFRESH; // refresh wins over a new request
						cnt <= '0;
					end else if (bus_cs && !ack_o) begin
						state <= we_i ? ST_WRITE : ST_READ;
						step <= '0;
					end
				end

				ST_REFRESH: begin
					cnt <= cnt + 1'b1;
					if (cnt == GAP_LAST) begin
						cnt <= '0;
						state <= ST_IDLE;
					end
				end

				ST_READ: begin
					step <= step + 1'b1;
					if (step == READ_CAP_STEP) begin
						state <= ST_PRECHARGE;
						step <= '0;
					end
				end

				ST_WRITE: begin
					step <= step + 1'b1;
					if (step == WRITE_LAST) begin
						state <= ST_PRECHARGE;
						step <= '0;
					end
				end

				ST_PRECHARGE: begin
					step <= step + 1'b1;
					if (step == 3'd1) begin
						ack_o <= 1'b1;
						state <= ST_IDLE;
						step <= '0;
					end
				end

				default: begin
					state <= ST_INIT;
					step <= '0;
				end
			endcase
		end
	end

	// read data holds until the next read
	always_ff @(posedge clk_sys) begin
		if (state == ST_READ && step == READ_CAP_STEP)
			dat_o <= dq_in_i;
	end

	always_comb begin
		cmd_o = CMD_NOP;
		addr_o = '0;
		ba_o = '0;
		dqm_o = 4'b1111;
		dq_oe_o = 1'b0;
		case (state)
			ST_INIT: begin
				case (step)
					3'd1: begin
						cmd_o = CMD_PRE;
						addr_o[10] = 1'b1; // all banks
					end
					3'd3: begin
						if (cnt == '0)
							cmd_o = CMD_REF;
					end
					3'd4: begin
						cmd_o = CMD_MRS;
						addr_o = `SDRAM_MODE_WORD;
					end
					default: ;
				endcase
			end
			ST_REFRESH: begin
				if (cnt == '0)
					cmd_o = CMD_REF;
			end
			ST_READ: begin
				ba_o = bus_addr.f.bank;
				if (step == 3'd0) begin
					cmd_o = CMD_ACT;
					addr_o = bus_addr.f.row;
				end else if (step == 3'd2) begin
					cmd_o = CMD_READ;
					addr_o = col_addr;
				end
				if (step >= 3'd2)
					dqm_o = 4'b0000; // dqm read latency
			end
			ST_WRITE: begin
				ba_o = bus_addr.f.bank;
				dq_oe_o = 1'b1;
				if (step == 3'd0) begin
					cmd_o = CMD_ACT;
					addr_o = bus_addr.f.row;
				end else if (step == 3'd2) begin
					cmd_o = CMD_WRITE;
					addr_o = col_addr;
					dqm_o = ~sel_i; // masks unselected bytes
				end
			end
			ST_PRECHARGE: begin
				if (step == 3'd0) begin
					cmd_o = CMD_PRE;
					addr_o[10] = 1'b1;
				end
			end
			default: ;
		endcase
	end

	assign dq_out_o = dat_i;
	assign refresh_taken_o = (state == ST_REFRESH) && (cnt == '0);
	assign init_done_o = (state != ST_INIT);

endmodule

// File: src/sdram_pkg.sv
`include "sdram_config.svh"

package sdram_pkg;

	// {cs_n, ras_n, cas_n, we_n}
	typedef enum logic [3:0] {
		CMD_MRS   = 4'b0000,
		CMD_REF   = 4'b0001,
		CMD_PRE   = 4'b0010,
		CMD_ACT   = 4'b0011,
		CMD_WRITE = 4'b0100,
		CMD_READ  = 4'b0101,
		CMD_NOP   = 4'b0111,
		CMD_DESL  = 4'b1000
	} sdram_cmd_e;

	typedef struct packed {
		logic [31-`SDRAM_BANK_W-`SDRAM_ROW_W-`SDRAM_COL_W-2:0] rsvd;
		logic [`SDRAM_BANK_W-1:0] bank;
		logic [`SDRAM_ROW_W-1:0] row;
		logic [`SDRAM_COL_W-1:0] col;
		logic [1:0] byte_off; // always 0 on the word bus
	} sdram_addr_fields_t;

	// one bus address, flat or split into dram coordinates
	typedef union packed {
		logic [31:0] word;
		sdram_addr_fields_t f;
	} sdram_addr_u;

endpackage

// File: src/sdram_refresh_timer.sv
`include "sdram_config.svh"

module sdram_refresh_timer (
	input  logic clk_sys,
	input  logic rst_i,
	input  logic enable_i,
	input  logic refresh_taken_i,
	output logic refresh_pending_o
);

	localparam int TW = `SDRAM_TIMER_W;
	localparam logic [TW-1:0] INTERVAL_LAST = TW'(`SDRAM_REFRESH_INTERVAL - 1);

	logic [TW-1:0] count;

	always_ff @(posedge clk_sys) begin
		if (rst_i) begin
			count <= '0;
			refresh_pending_o <= 1'b0;
		end else if (refresh_taken_i) begin
			count <= '0; // restart interval
			refresh_pending_o <= 1'b0;
		end else if (enable_i && !refresh_pending_o) begin
			if (count == INTERVAL_LAST) begin
				refresh_pending_o <= 1'b1; // sticky until taken
			end else begin
				count <= count + 1'b1;
			end
		end
	end

endmodule

// File: src/sdram_top.sv
module sdram_top
	import sdram_pkg::*;
(
	input  logic        clk_sys,
	input  logic        rst_i,
	input  logic        cyc_i,
	input  logic        stb_i,
	input  logic        we_i,
	input  logic [3:0]  sel_i,
	input  logic [31:0] adr_i,
	input  logic [31:0] dat_i,
	output logic        ack_o,
	output logic [31:0] dat_o,
	inout  wire  [31:0] dram_dq_io,
	output logic [12:0] dram0_a_o,
	output logic [1:0]  dram0_ba_o,
	output logic        dram0_ldqm_o,
	output logic        dram0_udqm_o,
	output logic        dram0_we_n_o,
	output logic        dram0_cas_n_o,
	output logic        dram0_ras_n_o,
	output logic        dram0_cs_n_o,
	output logic        dram0_clk_o,
	output logic        dram0_cke_o,
	output logic [12:0] dram1_a_o,
	output logic [1:0]  dram1_ba_o,
	output logic        dram1_ldqm_o,
	output logic        dram1_udqm_o,
	output logic        dram1_we_n_o,
	output logic        dram1_cas_n_o,
	output logic        dram1_ras_n_o,
	output logic        dram1_cs_n_o,
	output logic        dram1_clk_o,
	output logic        dram1_cke_o
);

	sdram_cmd_e  cmd;
	logic [12:0] addr;
	logic [1:0]  ba;
	logic [3:0]  dqm;
	logic        dq_oe;
	logic [31:0] dq_out;
	logic        init_done;
	logic        refresh_pending;
	logic        refresh_taken;
	logic        cs_n, ras_n, cas_n, we_n;

	sdram_refresh_timer sdram_refresh_timer_inst (
		.clk_sys           (clk_sys),
		.rst_i             (rst_i),
		.enable_i          (init_done),
		.refresh_taken_i   (refresh_taken),
		.refresh_pending_o (refresh_pending)
	);

	sdram_ctrl sdram_ctrl_inst (
		.clk_sys           (clk_sys),
		.rst_i             (rst_i),
		.cyc_i             (cyc_i),
		.stb_i             (stb_i),
		.we_i              (we_i),
		.sel_i             (sel_i),
		.adr_i             (adr_i),
		.dat_i             (dat_i),
		.ack_o             (ack_o),
		.dat_o             (dat_o),
		.refresh_pending_i (refresh_pending),
		.refresh_taken_o   (refresh_taken),
		.init_done_o       (init_done),
		.cmd_o             (cmd),
		.addr_o            (addr),
		.ba_o              (ba),
		.dqm_o             (dqm),
		.dq_oe_o           (dq_oe),
		.dq_out_o          (dq_out),
		.dq_in_i           (dram_dq_io)
	);

	assign {cs_n, ras_n, cas_n, we_n} = cmd;
	assign dram_dq_io = dq_oe ? dq_out : 32'bz;

	// both chips share the command bus
	assign dram0_a_o = addr;
	assign dram1_a_o = addr;
	assign dram0_ba_o = ba;
	assign dram1_ba_o = ba;
	assign dram0_cs_n_o = cs_n;
	assign dram1_cs_n_o = cs_n;
	assign dram0_ras_n_o = ras_n;
	assign dram1_ras_n_o = ras_n;
	assign dram0_cas_n_o = cas_n;
	assign dram1_cas_n_o = cas_n;
	assign dram0_we_n_o = we_n;
	assign dram1_we_n_o = we_n;

	assign dram0_ldqm_o = dqm[0]; // chip 0 holds the low half word
	assign dram0_udqm_o = dqm[1];
	assign dram1_ldqm_o = dqm[2];
	assign dram1_udqm_o = dqm[3];

	assign dram0_clk_o = clk_sys;
	assign dram1_clk_o = clk_sys;
	assign dram0_cke_o = 1'b1;
	assign dram1_cke_o = 1'b1;

endmodule

// File: verif/sdram_model.sv
`include "sdram_config.svh"

module sdram_model
	import sdram_pkg::*;
(
	input  logic        clk_i,
	input  logic [12:0] a0_i,
	input  logic [1:0]  ba0_i,
	input  logic        ldqm0_i,
	input  logic        udqm0_i,
	input  logic        cs_n0_i,
	input  logic        ras_n0_i,
	input  logic        cas_n0_i,
	input  logic        we_n0_i,
	input  logic [12:0] a1_i,
	input  logic [1:0]  ba1_i,
	input  logic        ldqm1_i,
	input  logic        udqm1_i,
	input  logic        cs_n1_i,
	input  logic        ras_n1_i,
	input  logic        cas_n1_i,
	input  logic        we_n1_i,
	inout  wire  [31:0] dq_io
);

	localparam int CL = `SDRAM_CAS_LATENCY;

	logic [15:0] mem_lo [int]; // chip 0
	logic [15:0] mem_hi [int]; // chip 1
	logic [3:0]  bank_open = '0;
	logic [12:0] open_row [4];
	logic [CL:0] rd_pipe = '0;
	logic [31:0] rd_data;
	logic        drive_en = 1'b0;
	logic [15:0] lo;
	logic [15:0] hi;
	int          key;
	int          rd_key;
	sdram_cmd_e  cmd;

	int          act_count = 0;
	int          ref_count = 0;
	int          violations = 0;
	logic        init_seen = 1'b0;
	sdram_cmd_e  cmd_log[$]; // everything before the first ACT
	logic [12:0] addr_log[$];

	assign cmd = sdram_cmd_e'({cs_n0_i, ras_n0_i, cas_n0_i, we_n0_i});
	assign dq_io = drive_en ? rd_data : 32'bz;

	task automatic report_violation(input string what);
		violations++;
		$display("protocol violation at %0t: %s", $time, what);
	endtask

	always @(posedge clk_i) begin
		key = {ba0_i, open_row[ba0_i], a0_i[8:0]};
		rd_pipe <= {rd_pipe[CL-1:0], cmd == CMD_READ};
		if ({a1_i, ba1_i, cs_n1_i, ras_n1_i, cas_n1_i, we_n1_i} !==
				{a0_i, ba0_i, cs_n0_i, ras_n0_i, cas_n0_i, we_n0_i})
			report_violation("chip 1 command pins differ from chip 0");
		if (act_count == 0 && cmd != CMD_NOP && cmd != CMD_ACT) begin
			cmd_log.push_back(cmd);
			addr_log.push_back(a0_i);
		end
		case (cmd)
			CMD_ACT: begin
				act_count++;
				if (bank_open != '0)
					report_violation("ACT while a row is open");
				bank_open[ba0_i] <= 1'b1;
				open_row[ba0_i] <= a0_i;
			end
			CMD_READ: begin
				if (!bank_open[ba0_i])
					report_violation("READ to a closed bank");
				rd_key <= key;
			end
			CMD_WRITE: begin
				if (!bank_open[ba0_i])
					report_violation("WRITE to a closed bank");
				lo = mem_lo.exists(key) ? mem_lo[key] : 16'hxxxx;
				hi = mem_hi.exists(key) ? mem_hi[key] : 16'hxxxx;
				if (!ldqm0_i) lo[7:0] = dq_io[7:0];
				if (!udqm0_i) lo[15:8] = dq_io[15:8];
				if (!ldqm1_i) hi[7:0] = dq_io[23:16];
				if (!udqm1_i) hi[15:8] = dq_io[31:24];
				mem_lo[key] = lo;
				mem_hi[key] = hi;
			end
			CMD_PRE: begin
				if (a0_i[10])
					bank_open <= '0; // all banks
				else
					bank_open[ba0_i] <= 1'b0;
			end
			CMD_REF: begin
				ref_count++;
				if (bank_open != '0)
					report_violation("REF while a row is open");
			end
			CMD_MRS: begin
				init_seen = 1'b1;
				if (bank_open != '0)
					report_violation("MRS while a row is open");
			end
			default: ;
		endcase
	end

	// data window spans the controller's capture edge
	always @(negedge clk_i) begin
		drive_en <= rd_pipe[CL];
		if (rd_pipe[CL]) begin
			rd_data[15:0] <= mem_lo.exists(rd_key) ? mem_lo[rd_key] : 16'hxxxx;
			rd_data[31:16] <= mem_hi.exists(rd_key) ? mem_hi[rd_key] : 16'hxxxx;
		end
	end

endmodule

// File: verif/tb_sdram.sv
`include "sdram_config.svh"

module tb_sdram
	import sdram_pkg::*;
();

	localparam int ACK_TIMEOUT = 100;
	localparam int INIT_TIMEOUT = 1000;
	localparam int BYTE_OPS = 60;
	localparam int HANDSHAKE_OPS = 30;
	localparam int RANDOM_OPS = 200;

	logic        clk_sys;
	logic        rst_i;
	logic        cyc;
	logic        stb;
	logic        we;
	logic [3:0]  sel;
	logic [31:0] adr;
	logic [31:0] dat_w;
	logic        ack;
	logic [31:0] dat_r;
	wire  [31:0] dram_dq;
	logic [12:0] dram0_a;
	logic [1:0]  dram0_ba;
	logic        dram0_ldqm;
	logic        dram0_udqm;
	logic        dram0_we_n;
	logic        dram0_cas_n;
	logic        dram0_ras_n;
	logic        dram0_cs_n;
	logic        dram0_clk;
	logic        dram0_cke;
	logic [12:0] dram1_a;
	logic [1:0]  dram1_ba;
	logic        dram1_ldqm;
	logic        dram1_udqm;
	logic        dram1_we_n;
	logic        dram1_cas_n;
	logic        dram1_ras_n;
	logic        dram1_cs_n;
	logic        dram1_clk;
	logic        dram1_cke;

	logic [31:0] lfsr;
	logic [31:0] ref_mem [64];
	logic        ack_prev = 1'b0;
	int          ack_rises = 0;
	int          cycle_count = 0;
	int          dram1_clk_rises = 0;
	int          errors = 0;
	int          errors_at_start = 0;
	int          tests_run = 0;
	int          tests_failed = 0;

	sdram_top sdram_top_inst (
		.clk_sys (clk_sys), .rst_i (rst_i),
		.cyc_i (cyc), .stb_i (stb), .we_i (we), .sel_i (sel),
		.adr_i (adr), .dat_i (dat_w), .ack_o (ack), .dat_o (dat_r),
		.dram_dq_io (dram_dq),
		.dram0_a_o (dram0_a), .dram0_ba_o (dram0_ba),
		.dram0_ldqm_o (dram0_ldqm), .dram0_udqm_o (dram0_udqm),
		.dram0_we_n_o (dram0_we_n), .dram0_cas_n_o (dram0_cas_n),
		.dram0_ras_n_o (dram0_ras_n), .dram0_cs_n_o (dram0_cs_n),
		.dram0_clk_o (dram0_clk), .dram0_cke_o (dram0_cke),
		.dram1_a_o (dram1_a), .dram1_ba_o (dram1_ba),
		.dram1_ldqm_o (dram1_ldqm), .dram1_udqm_o (dram1_udqm),
		.dram1_we_n_o (dram1_we_n), .dram1_cas_n_o (dram1_cas_n),
		.dram1_ras_n_o (dram1_ras_n), .dram1_cs_n_o (dram1_cs_n),
		.dram1_clk_o (dram1_clk), .dram1_cke_o (dram1_cke)
	);

	sdram_model sdram_model_inst (
		.clk_i (dram0_clk),
		.a0_i (dram0_a), .ba0_i (dram0_ba), .ldqm0_i (dram0_ldqm), .udqm0_i (dram0_udqm),
		.cs_n0_i (dram0_cs_n), .ras_n0_i (dram0_ras_n),
		.cas_n0_i (dram0_cas_n), .we_n0_i (dram0_we_n),
		.a1_i (dram1_a), .ba1_i (dram1_ba), .ldqm1_i (dram1_ldqm), .udqm1_i (dram1_udqm),
		.cs_n1_i (dram1_cs_n), .ras_n1_i (dram1_ras_n),
		.cas_n1_i (dram1_cas_n), .we_n1_i (dram1_we_n),
		.dq_io (dram_dq)
	);

	always #50 clk_sys = ~clk_sys;

	always @(posedge clk_sys)
		cycle_count <= cycle_count + 1;

	always @(posedge dram1_clk)
		dram1_clk_rises <= dram1_clk_rises + 1; // one per clk_sys cycle

	always @(negedge clk_sys) begin
		if (ack && !ack_prev)
			ack_rises <= ack_rises + 1;
		ack_prev <= ack;
		if (dram0_cke !== 1'b1 || dram1_cke !== 1'b1)
			report_error("cke not high on a dram chip");
	end

	function automatic logic [31:0] lfsr_bits(input int n);
		logic [31:0] v;
		int i;
		v = '0;
		for (i = 0; i < n; i++) begin
			v = {v[30:0], lfsr[0]};
			lfsr = {1'b0, lfsr[31:1]} ^ (lfsr[0] ? 32'h8020_0003 : 32'h0); // galois step
		end
		return v;
	endfunction

	// small window, banks and rows get reused
	function automatic logic [31:0] slot_addr(input logic [5:0] slot);
		sdram_addr_u a;
		a.word = '0;
		a.f.bank = slot[5:4];
		a.f.row = {slot[3], 11'h000, slot[2]};
		a.f.col = {slot[1], 7'h00, slot[0]};
		return a.word;
	endfunction

	task automatic report_error(input string msg);
		errors++;
		$display("Error at time %0t: %s", $time, msg);
	endtask

	task automatic stop_on_timeout(input string what);
		$display("timeout at %0t: %s", $time, what);
		$display("*** FAILED ***");
		$finish;
	endtask

	task automatic check_word(input string what, input logic [31:0] got, input logic [31:0] exp);
		if (got !== exp)
			report_error($sformatf("%s: read %h, expected %h", what, got, exp));
	endtask

	task automatic check_cmd(input string what, input sdram_cmd_e got, input sdram_cmd_e exp);
		if (got !== exp)
			report_error($sformatf("%s: command %s, expected %s", what, got.name(), exp.name()));
	endtask

	task automatic check_addr(input string what, input logic [12:0] got, input logic [12:0] exp);
		if (got !== exp)
			report_error($sformatf("%s: address %h, expected %h", what, got, exp));
	endtask

	task automatic check_count(input string what, input int got, input int exp, input bit at_least);
		if (at_least ? (got < exp) : (got != exp))
			report_error($sformatf("%s: got %0d, expected %s%0d", what, got,
				at_least ? "at least " : "", exp));
	endtask

	task automatic end_test(input int num, input string name);
		int n_err;
		n_err = errors - errors_at_start;
		tests_run++;
		if (n_err != 0)
			tests_failed++;
		$display("test %0d %s: %s (%0d errors)", num, name, n_err == 0 ? "ok" : "failed", n_err);
		errors_at_start = errors;
	endtask

	// entered and left just after a falling edge
	task automatic bus_access(input logic write, input logic [5:0] slot, input logic [3:0] be,
			input logic [31:0] data, input int hold, output logic [31:0] rdata);
		int n;
		int acts_before;
		acts_before = sdram_model_inst.act_count;
		cyc = 1'b1;
		stb = 1'b1;
		we = write;
		sel = be;
		adr = slot_addr(slot);
		dat_w = data;
		n = 0;
		do begin
			@(negedge clk_sys);
			n++;
		end while (!ack && n < ACK_TIMEOUT);
		if (!ack)
			stop_on_timeout("no ack on the bus");
		rdata = dat_r;
		repeat (hold) begin
			@(negedge clk_sys);
			if (!ack)
				report_error("ack dropped while stb was held");
		end
		check_count("ACTs for one request", sdram_model_inst.act_count - acts_before, 1, 0);
		cyc = 1'b0;
		stb = 1'b0;
		@(negedge clk_sys);
		if (ack)
			report_error("ack still high after stb dropped");
	endtask

	task automatic write_word(input logic [5:0] slot, input logic [3:0] be,
			input logic [31:0] data, input int hold);
		logic [31:0] unused;
		int b;
		bus_access(1'b1, slot, be, data, hold, unused);
		for (b = 0; b < 4; b++)
			if (be[b])
				ref_mem[slot][8*b +: 8] = data[8*b +: 8];
	endtask

	task automatic read_check(input logic [5:0] slot, input int hold, input string what);
		logic [31:0] rdata;
		bus_access(1'b0, slot, 4'h0, 32'h0, hold, rdata);
		check_word($sformatf("%s, slot %0d", what, slot), rdata, ref_mem[slot]);
	endtask

	initial begin
		logic [3:0] be;
		logic [5:0] slot;
		int i;
		int n;
		int requests;
		int acts_start;
		int rises_start;
		int init_cycle;
		int refs;
		lfsr = 32'hcc675ba7;
		clk_sys = 1'b0;
		rst_i = 1'b1;
		cyc = 1'b0;
		stb = 1'b0;
		we = 1'b0;
		sel = 4'h0;
		adr = '0;
		dat_w = '0;
		repeat (2) @(negedge clk_sys);
		rst_i = 1'b0;

		check_count("ack after reset", (ack === 1'b0) ? 0 : 1, 0, 0);
		n = 0;
		while (!sdram_model_inst.init_seen && n < INIT_TIMEOUT) begin
			@(negedge clk_sys);
			n++;
		end
		if (!sdram_model_inst.init_seen)
			stop_on_timeout("init never reached the mode register set");
		init_cycle = cycle_count;
		check_count("ACTs during init", sdram_model_inst.act_count, 0, 0);
		check_count("init commands", sdram_model_inst.cmd_log.size(), `SDRAM_INIT_REFRESHES + 2, 0);
		if (sdram_model_inst.cmd_log.size() == `SDRAM_INIT_REFRESHES + 2) begin
			check_cmd("init step 0", sdram_model_inst.cmd_log[0], CMD_PRE);
			check_addr("precharge-all a10", sdram_model_inst.addr_log[0] & 13'h400, 13'h400);
			for (i = 1; i <= `SDRAM_INIT_REFRESHES; i++)
				check_cmd($sformatf("init step %0d", i), sdram_model_inst.cmd_log[i], CMD_REF);
			check_cmd("init mode set", sdram_model_inst.cmd_log[i], CMD_MRS);
			check_addr("mode word", sdram_model_inst.addr_log[i], `SDRAM_MODE_WORD);
		end
		end_test(1, "init sequence");

		for (i = 0; i < 64; i++) begin
			write_word(6'(i), 4'hf, lfsr_bits(32), 0);
			read_check(6'(i), 0, "full word readback");
		end
		end_test(2, "full-word write and read");

		for (i = 0; i < BYTE_OPS; i++) begin
			slot = 6'(lfsr_bits(6));
			do
				be = 4'(lfsr_bits(4));
			while (be == 4'hf || be == 4'h0); // partial selects only
			write_word(slot, be, lfsr_bits(32), 0);
			read_check(slot, 0, "byte select readback");
		end
		end_test(3, "byte selects");

		requests = 0;
		acts_start = sdram_model_inst.act_count;
		rises_start = ack_rises;
		for (i = 0; i < HANDSHAKE_OPS; i++) begin
			slot = 6'(lfsr_bits(6));
			if (lfsr_bits(1))
				write_word(slot, 4'(lfsr_bits(4)), lfsr_bits(32), 1 + lfsr_bits(2));
			else
				read_check(slot, 1 + lfsr_bits(2), "held read");
			requests++;
		end
		check_count("ACTs against requests", sdram_model_inst.act_count - acts_start, requests, 0);
		check_count("ack rises against requests", ack_rises - rises_start, requests, 0);
		end_test(4, "bus handshake");

		for (i = 0; i < RANDOM_OPS; i++) begin
			slot = 6'(lfsr_bits(6));
			if (lfsr_bits(1))
				write_word(slot, 4'(lfsr_bits(4)), lfsr_bits(32), lfsr_bits(1));
			else
				read_check(slot, lfsr_bits(1), "random read");
		end
		refs = sdram_model_inst.ref_count - `SDRAM_INIT_REFRESHES;
		check_count("refreshes after init", refs,
			(cycle_count - init_cycle) / `SDRAM_REFRESH_INTERVAL - 1, 1);
		check_count("model protocol violations", sdram_model_inst.violations, 0, 0);
		check_count("chip 1 clock rises", dram1_clk_rises, cycle_count, 0);
		end_test(5, "periodic refresh");

		$display("tests run %0d, tests failed %0d, errors %0d", tests_run, tests_failed, errors);
		if (errors == 0)
			$display("*** PASSED ***");
		else
			$display("*** FAILED ***");
		$finish;
	end

endmodule
